// ==== Makefile ====
.PHONY: help test clean

help:
	@echo "make test   build with Verilator and run the testbench"
	@echo "make clean  remove the Verilator build folder"
	@echo "make help   show this list"

test:
	verilator --binary --timing --assert -Wno-fatal -f vlog.f \
		--top-module pattern_tb -o pattern_sim
	@out=$$(./obj_dir/pattern_sim); echo "$$out"; \
	echo "$$out" | grep -q "Test completed successfully"

clean:
	rm -rf obj_dir

// ==== hw/pattern_apb_regs.sv ====
// pattern_apb_regs: APB slave with control, status and pattern registers
`timescale 1ns/1ns
`default_nettype none

`include "scan_settings.svh"

module pattern_apb_regs (
    input  logic                      clk,
    input  logic                      rst,
    input  logic                      psel,
    input  logic                      penable,
    input  logic                      pwrite,
    input  logic [`APB_ADDR_BITS-1:0] paddr,
    input  logic [31:0]               pwdata,
    output logic [31:0]               prdata,
    output logic                      pready,
    output logic                      pslverr,
    input  logic                      frame_err,
    pattern_cfg_if.regs               cfg
);
    import scan_pkg::*;

    localparam logic [`APB_ADDR_BITS-3:0] PAT_WORDS = (`APB_ADDR_BITS - 2)'(`PATTERN_SIZE);

    logic                      access;
    logic                      wr_en;
    logic                      sel_ctrl;
    logic                      sel_status;
    logic                      sel_pat;
    logic [`APB_ADDR_BITS-1:0] pat_offset;
    logic [`APB_ADDR_BITS-3:0] pat_word;
    logic                      scan_enable;
    logic                      frame_flag;
    logic [3:0]                count_field;

    assign access = psel && penable;
    assign wr_en  = access && pwrite;

    // address decode
    assign pat_offset = paddr - ADDR_PATTERN;
    assign pat_word   = pat_offset[`APB_ADDR_BITS-1:2];
    assign sel_ctrl   = (paddr == ADDR_CTRL);
    assign sel_status = (paddr == ADDR_STATUS);
    assign sel_pat    = (paddr >= ADDR_PATTERN) && (pat_offset[1:0] == 2'b00)
                        && (pat_word < PAT_WORDS);

    assign pready  = access;
    assign pslverr = access && !(sel_ctrl || sel_status || sel_pat);

    assign cfg.pat_wr      = wr_en && sel_pat;
    assign cfg.pat_index   = pat_idx_t'(pat_word);
    assign cfg.pat_wdata   = pwdata[`CHAR_BITS-1:0];
    assign cfg.rearm       = wr_en && sel_ctrl && pwdata[1];
    assign cfg.scan_enable = scan_enable;

    always_ff @(posedge clk) begin
        if (rst) begin
            scan_enable <= 1'b0;
            frame_flag  <= 1'b0;
        end else begin
            if (wr_en && sel_ctrl) begin
                scan_enable <= pwdata[0];
            end
            // a new framing error wins over a rearm in the same cycle
            if (frame_err) begin
                frame_flag <= 1'b1;
            end else if (cfg.rearm) begin
                frame_flag <= 1'b0;
            end
        end
    end

    assign count_field = 4'(cfg.info_count);

    always_comb begin
        prdata = '0;
        if (sel_ctrl) begin
            prdata[0] = scan_enable;
        end else if (sel_status) begin
            prdata[7:0] = {count_field, 1'b0, frame_flag,
                           cfg.state == SCAN_DONE, cfg.state != SCAN_MATCH};
        end else if (sel_pat) begin
            prdata[`CHAR_BITS-1:0] = cfg.pat_rdata;
        end
    end

endmodule

`default_nettype wire

// ==== hw/pattern_cfg_if.sv ====
// pattern_cfg_if: pattern writes, readback, control and status between regs and searcher
`timescale 1ns/1ns
`default_nettype none

interface pattern_cfg_if;
    import uart_pkg::*;
    import scan_pkg::*;

    logic        pat_wr;
    pat_idx_t    pat_index;
    char_t       pat_wdata;
    logic        scan_enable;
    logic        rearm;
    char_t       pat_rdata;
    scan_state_t state;
    info_cnt_t   info_count;

    modport regs (
        output pat_wr, pat_index, pat_wdata, scan_enable, rearm,
        input  pat_rdata, state, info_count
    );

    modport search (
        input  pat_wr, pat_index, pat_wdata, scan_enable, rearm,
        output pat_rdata, state, info_count
    );

endinterface

`default_nettype wire

// ==== hw/pattern_search.sv ====
// pattern_search: pattern memory, match state machine and info byte capture
`timescale 1ns/1ns
`default_nettype none

`include "scan_settings.svh"

module pattern_search (
    input  logic            clk,
    input  logic            rst,
    input  uart_pkg::char_t char_data,
    input  logic            char_valid,
    pattern_cfg_if.search   cfg,
    output uart_pkg::char_t info_data,
    output logic            info_valid
);
    import uart_pkg::*;
    import scan_pkg::*;

    localparam pat_idx_t  LAST_IDX  = pat_idx_t'(`PATTERN_SIZE - 1);
    localparam info_cnt_t LAST_INFO = info_cnt_t'(`INFO_SIZE - 1);

    char_t       pattern [`PATTERN_SIZE];
    pat_idx_t    match_idx;
    info_cnt_t   info_cnt;
    scan_state_t state;
    logic        char_take;
    logic        char_hit;
    logic        first_hit;

    always_ff @(posedge clk) begin
        if (rst) begin
            pattern <= '{default: '0};
        end else if (cfg.pat_wr) begin
            pattern[cfg.pat_index] <= cfg.pat_wdata;
        end
    end

    // indexes past the pattern read as zero
    assign cfg.pat_rdata = (cfg.pat_index <= LAST_IDX) ? pattern[cfg.pat_index] : '0;

    assign char_take = char_valid && cfg.scan_enable;
    assign char_hit  = (char_data == pattern[match_idx]);
    assign first_hit = (char_data == pattern[0]);

    always_ff @(posedge clk) begin
        if (rst) begin
            state      <= SCAN_MATCH;
            match_idx  <= '0;
            info_cnt   <= '0;
            info_valid <= 1'b0;
        end else begin
            info_valid <= 1'b0;
            if (cfg.rearm) begin
                state     <= SCAN_MATCH;
                match_idx <= '0;
                info_cnt  <= '0;
            end else if (char_take) begin
                case (state)
                    SCAN_MATCH: begin
                        if (char_hit && match_idx == LAST_IDX) begin
                            state     <= SCAN_INFO;
                            match_idx <= '0;
                        end else if (char_hit) begin
                            match_idx <= match_idx + 1'b1;
                        end else begin
                            // the breaking character may itself start a new match
                            match_idx <= first_hit ? pat_idx_t'(1) : '0;
                        end
                    end
                    SCAN_INFO: begin
                        info_valid <= 1'b1;
                        info_cnt   <= info_cnt + 1'b1;
                        if (info_cnt == LAST_INFO) begin
                            state <= SCAN_DONE;
                        end
                    end
                    default: ;
                endcase
            end
        end
    end

    always_ff @(posedge clk) begin
        if (char_take && state == SCAN_INFO) begin
            info_data <= char_data;
        end
    end

    assign cfg.state      = state;
    assign cfg.info_count = info_cnt;

endmodule

`default_nettype wire

// ==== hw/pattern_top.sv ====
// pattern_top: uart receiver, pattern searcher and APB register block
`timescale 1ns/1ns
`default_nettype none

`include "scan_settings.svh"

module pattern_top (
    input  logic                      clk,
    input  logic                      rst,
    input  logic                      psel,
    input  logic                      penable,
    input  logic                      pwrite,
    input  logic [`APB_ADDR_BITS-1:0] paddr,
    input  logic [31:0]               pwdata,
    output logic [31:0]               prdata,
    output logic                      pready,
    output logic                      pslverr,
    input  logic                      rx,
    output uart_pkg::char_t           info_data,
    output logic                      info_valid
);
    import uart_pkg::*;

    char_t char_data;
    logic  char_valid;
    logic  frame_err;

    pattern_cfg_if cfg_if ();

    uart_rx u_rx (
        .clk        (clk),
        .rst        (rst),
        .rx         (rx),
        .char_data  (char_data),
        .char_valid (char_valid),
        .frame_err  (frame_err)
    );

    pattern_search u_search (
        .clk        (clk),
        .rst        (rst),
        .char_data  (char_data),
        .char_valid (char_valid),
        .cfg        (cfg_if.search),
        .info_data  (info_data),
        .info_valid (info_valid)
    );

    pattern_apb_regs u_regs (
        .clk       (clk),
        .rst       (rst),
        .psel      (psel),
        .penable   (penable),
        .pwrite    (pwrite),
        .paddr     (paddr),
        .pwdata    (pwdata),
        .prdata    (prdata),
        .pready    (pready),
        .pslverr   (pslverr),
        .frame_err (frame_err),
        .cfg       (cfg_if.regs)
    );

endmodule

`default_nettype wire

// ==== hw/scan_pkg.sv ====
// pattern scan types: match index, info count, scan states, register map
`default_nettype none

`include "scan_settings.svh"

package scan_pkg;

    // holds 0 .. PATTERN_SIZE-1
    typedef logic [$clog2(`PATTERN_SIZE)-1:0] pat_idx_t;

    // holds 0 .. INFO_SIZE
    typedef logic [$clog2(`INFO_SIZE + 1)-1:0] info_cnt_t;

    typedef enum logic [1:0] {SCAN_MATCH, SCAN_INFO, SCAN_DONE} scan_state_t;

    // pattern entry i sits at ADDR_PATTERN + 4*i
    typedef enum logic [`APB_ADDR_BITS-1:0] {
        ADDR_CTRL    = 'h00,
        ADDR_STATUS  = 'h04,
        ADDR_PATTERN = 'h10
    } reg_addr_t;

endpackage

`default_nettype wire

// ==== hw/scan_settings.svh ====
// build-time sizes for the UART pattern scanner: character width, pattern, info and baud
`ifndef SCAN_SETTINGS_SVH
`define SCAN_SETTINGS_SVH

// bits per received character
`define CHAR_BITS 8

// number of characters in the searched pattern
`define PATTERN_SIZE 10

// info characters handed out after a full match
`define INFO_SIZE 2

// clock cycles per serial bit, small so simulation stays short
`define CLKS_PER_BIT 4

`define APB_ADDR_BITS 8

`endif

// ==== hw/uart_pkg.sv ====
// uart receiver types: character, baud and bit counters, receiver states
`default_nettype none

`include "scan_settings.svh"

package uart_pkg;

    typedef logic [`CHAR_BITS-1:0] char_t;

    // counts clocks within one bit period
    typedef logic [$clog2(`CLKS_PER_BIT)-1:0] baud_cnt_t;
    typedef logic [$clog2(`CHAR_BITS)-1:0] bit_idx_t;

    typedef enum logic [1:0] {RX_IDLE, RX_START, RX_DATA, RX_STOP} rx_state_t;

endpackage

`default_nettype wire

// ==== hw/uart_rx.sv ====
// uart_rx: oversampling 8N1 receiver with character strobe and framing error
`timescale 1ns/1ns
`default_nettype none

`include "scan_settings.svh"

module uart_rx (
    input  logic            clk,
    input  logic            rst,
    input  logic            rx,
    output uart_pkg::char_t char_data,
    output logic            char_valid,
    output logic            frame_err
);
    import uart_pkg::*;

    localparam baud_cnt_t HALF_BIT = baud_cnt_t'(`CLKS_PER_BIT / 2 - 1);
    localparam baud_cnt_t FULL_BIT = baud_cnt_t'(`CLKS_PER_BIT - 1);
    localparam bit_idx_t  LAST_BIT = bit_idx_t'(`CHAR_BITS - 1);

    logic      rx_meta;
    logic      rx_sync;
    rx_state_t state;
    baud_cnt_t clk_cnt;
    bit_idx_t  bit_idx;
    char_t     shift_reg;
    logic      sample_data;

    // two-flop synchronizer, line idles high
    always_ff @(posedge clk) begin
        if (rst) begin
            rx_meta <= 1'b1;
            rx_sync <= 1'b1;
        end else begin
            rx_meta <= rx;
            rx_sync <= rx_meta;
        end
    end

    assign sample_data = (state == RX_DATA) && (clk_cnt == FULL_BIT);

    always_ff @(posedge clk) begin
        if (rst) begin
            state      <= RX_IDLE;
            clk_cnt    <= '0;
            bit_idx    <= '0;
            char_valid <= 1'b0;
            frame_err  <= 1'b0;
        end else begin
            char_valid <= 1'b0;
            frame_err  <= 1'b0;
            case (state)
                RX_IDLE: begin
                    clk_cnt <= '0;
                    if (!rx_sync) begin
                        state <= RX_START;
                    end
                end
                RX_START: begin
                    if (clk_cnt == HALF_BIT) begin
                        clk_cnt <= '0;
                        bit_idx <= '0;
                        // a start bit gone high by mid-bit was a glitch
                        state   <= rx_sync ? RX_IDLE : RX_DATA;
                    end else begin
                        clk_cnt <= clk_cnt + 1'b1;
                    end
                end
                RX_DATA: begin
                    if (clk_cnt == FULL_BIT) begin
                        clk_cnt <= '0;
                        bit_idx <= bit_idx + 1'b1;
                        if (bit_idx == LAST_BIT) begin
                            state <= RX_STOP;
                        end
                    end else begin
                        clk_cnt <= clk_cnt + 1'b1;
                    end
                end
                RX_STOP: begin
                    if (clk_cnt == FULL_BIT) begin
                        clk_cnt    <= '0;
                        char_valid <= rx_sync;
                        frame_err  <= !rx_sync;
                        state      <= RX_IDLE;
                    end else begin
                        clk_cnt <= clk_cnt + 1'b1;
                    end
                end
                default: state <= RX_IDLE;
            endcase
        end
    end

    // lsb arrives first, so shift in from the top
    always_ff @(posedge clk) begin
        if (sample_data) begin
            shift_reg <= {rx_sync, shift_reg[`CHAR_BITS-1:1]};
        end
    end

    assign char_data = shift_reg;

endmodule

`default_nettype wire

// ==== verification/pattern_properties.sv ====
// pattern_properties: APB access and info strobe assertions, bound to pattern_top
`timescale 1ns/1ns
`default_nettype none

module pattern_properties (
    input logic clk,
    input logic rst,
    input logic psel,
    input logic penable,
    input logic pready,
    input logic pslverr,
    input logic info_valid
);

    // no wait states in any access cycle
    ready_in_access: assert property (@(posedge clk) disable iff (rst)
        (psel && penable) |-> pready)
        else $error("pready low during an APB access cycle");

    info_single_cycle: assert property (@(posedge clk) disable iff (rst)
        info_valid |=> !info_valid)
        else $error("info_valid held for two cycles");

    slverr_in_access: assert property (@(posedge clk) disable iff (rst)
        pslverr |-> (psel && penable))
        else $error("pslverr outside an APB access cycle");

endmodule

bind pattern_top pattern_properties u_props (
    .clk        (clk),
    .rst        (rst),
    .psel       (psel),
    .penable    (penable),
    .pready     (pready),
    .pslverr    (pslverr),
    .info_valid (info_valid)
);

`default_nettype wire

// ==== verification/pattern_tb.sv ====
// pattern_tb: clock, reset, APB and serial drivers, stimulus table, compare tasks, watchdog
`timescale 1ns/1ns
`default_nettype none

`include "scan_settings.svh"

module pattern_tb;
    import uart_pkg::*;
    import scan_pkg::*;

    localparam int         CLK_PERIOD = 40;
    localparam int         NUM_ROWS   = 6;
    localparam int         MAX_CHARS  = 24;
    localparam logic [8:0] FILL       = 9'h100;

    logic                      clk = 1'b0;
    logic                      rst;
    logic                      psel;
    logic                      penable;
    logic                      pwrite;
    logic [`APB_ADDR_BITS-1:0] paddr;
    logic [31:0]               pwdata;
    logic [31:0]               prdata;
    logic                      pready;
    logic                      pslverr;
    logic                      rx;
    char_t                     info_data;
    logic                      info_valid;

    // stimulus table, one row per test
    string       row_name  [NUM_ROWS];
    string       row_pat   [NUM_ROWS];
    logic        row_en    [NUM_ROWS];
    logic [8:0]  row_chars [NUM_ROWS][MAX_CHARS];
    int          row_len   [NUM_ROWS];
    int          row_bad   [NUM_ROWS];
    string       row_info  [NUM_ROWS];
    scan_state_t row_state [NUM_ROWS];
    logic        row_frame [NUM_ROWS];

    char_t got [$];
    int    watch_cycles;
    logic  table_ready = 1'b0;

    always #(CLK_PERIOD / 2) clk = ~clk;

    pattern_top uut (
        .clk        (clk),
        .rst        (rst),
        .psel       (psel),
        .penable    (penable),
        .pwrite     (pwrite),
        .paddr      (paddr),
        .pwdata     (pwdata),
        .prdata     (prdata),
        .pready     (pready),
        .pslverr    (pslverr),
        .rx         (rx),
        .info_data  (info_data),
        .info_valid (info_valid)
    );

    // info bytes are one-cycle strobes, taken in the low clock phase
    always @(negedge clk) begin
        if (info_valid) begin
            got.push_back(info_data);
        end
    end

    task automatic stop_on_error();
        $display("Test failed");
        $fatal(1, "stopped at the first error");
    endtask

    task automatic check_char(input string name, input char_t exp, input char_t act);
        if (act !== exp) begin
            $display("[ERROR] %s expected 0x%02h actual 0x%02h", name, exp, act);
            stop_on_error();
        end
    endtask

    // found is bit 0, done bit 1, framing flag bit 2, count in bits 7:4
    task automatic check_status(input string name, input scan_state_t exp_state,
                                input info_cnt_t exp_count, input logic exp_frame,
                                input logic [31:0] word);
        if (word[0] !== (exp_state != SCAN_MATCH) || word[1] !== (exp_state == SCAN_DONE)
            || word[2] !== exp_frame || word[7:4] !== 4'(exp_count)) begin
            $display("[ERROR] %s expected %s count %0d frame %0b actual status 0x%02h",
                     name, exp_state.name(), exp_count, exp_frame, word[7:0]);
            stop_on_error();
        end
    endtask

    task automatic check_flag(input string name, input logic exp, input logic act);
        if (act !== exp) begin
            $display("[ERROR] %s expected %0b actual %0b", name, exp, act);
            stop_on_error();
        end
    endtask

    task automatic check_count(input string name, input int exp, input int act);
        if (act != exp) begin
            $display("[ERROR] %s expected %0d info bytes actual %0d", name, exp, act);
            stop_on_error();
        end
    endtask

    // bus tasks start and end on a falling edge
    task automatic apb_write(input logic [`APB_ADDR_BITS-1:0] addr, input logic [31:0] data);
        psel    = 1'b1;
        penable = 1'b0;
        pwrite  = 1'b1;
        paddr   = addr;
        pwdata  = data;
        @(negedge clk);
        penable = 1'b1;
        @(negedge clk);
        psel    = 1'b0;
        penable = 1'b0;
    endtask

    task automatic apb_read(input logic [`APB_ADDR_BITS-1:0] addr, output logic [31:0] data,
                            output logic err);
        psel    = 1'b1;
        penable = 1'b0;
        pwrite  = 1'b0;
        paddr   = addr;
        @(negedge clk);
        penable = 1'b1;
        // sample in the middle of the low phase of the access cycle
        #(CLK_PERIOD / 4);
        data = prdata;
        err  = pslverr;
        @(negedge clk);
        psel    = 1'b0;
        penable = 1'b0;
    endtask

    // start, eight data bits lsb first, stop, then two idle bit times
    task automatic uart_send(input char_t ch, input logic bad_stop);
        rx = 1'b0;
        repeat (`CLKS_PER_BIT) @(negedge clk);
        for (int b = 0; b < `CHAR_BITS; b++) begin
            rx = ch[b];
            repeat (`CLKS_PER_BIT) @(negedge clk);
        end
        rx = !bad_stop;
        repeat (`CLKS_PER_BIT) @(negedge clk);
        rx = 1'b1;
        repeat (2 * `CLKS_PER_BIT) @(negedge clk);
    endtask

    task automatic set_row(input int r, input string name, input string pat, input logic en,
                           input int bad, input string info, input scan_state_t st,
                           input logic frame);
        row_name[r]  = name;
        row_pat[r]   = pat;
        row_en[r]    = en;
        row_bad[r]   = bad;
        row_info[r]  = info;
        row_state[r] = st;
        row_frame[r] = frame;
        row_len[r]   = 0;
    endtask

    task automatic push_char(input int r, input logic [8:0] c);
        row_chars[r][row_len[r]] = c;
        row_len[r]++;
    endtask

    task automatic push_fill(input int r, input int n);
        for (int i = 0; i < n; i++) push_char(r, FILL);
    endtask

    task automatic push_text(input int r, input string s);
        for (int i = 0; i < s.len(); i++) push_char(r, {1'b0, s[i]});
    endtask

    task automatic append_pattern(input int r, input int first, input int last);
        for (int i = first; i <= last; i++) push_char(r, {1'b0, row_pat[r][i]});
    endtask

    task automatic build_table();
        set_row(0, "full_match", "SYNC_HEAD!", 1'b1, -1, "ab", SCAN_DONE, 1'b0);
        push_fill(0, 2);
        append_pattern(0, 0, 9);
        push_text(0, "abcd");
        set_row(1, "scan_disabled", "SYNC_HEAD!", 1'b0, -1, "", SCAN_MATCH, 1'b0);
        append_pattern(1, 0, 9);
        push_text(1, "ab");
        // break at entry 5 with the first entry, which restarts at index 1
        set_row(2, "overlap_restart", "0123456789", 1'b1, -1, "xy", SCAN_DONE, 1'b0);
        push_fill(2, 1);
        append_pattern(2, 0, 4);
        append_pattern(2, 0, 0);
        append_pattern(2, 1, 9);
        push_text(2, "xy");
        set_row(3, "broken_partial", "0123456789", 1'b1, -1, "", SCAN_MATCH, 1'b0);
        append_pattern(3, 0, 6);
        push_fill(3, 1);
        append_pattern(3, 1, 9);
        push_fill(3, 2);
        // position 4 carries pattern entry 3
        set_row(4, "bad_stop_in_pattern", "SYNC_HEAD!", 1'b1, 4, "", SCAN_MATCH, 1'b1);
        push_fill(4, 1);
        append_pattern(4, 0, 9);
        push_text(4, "ab");
        set_row(5, "bad_stop_outside", "SYNC_HEAD!", 1'b1, 1, "ab", SCAN_DONE, 1'b1);
        push_fill(5, 2);
        append_pattern(5, 0, 9);
        push_text(5, "ab");
    endtask

    task automatic run_row(input int r);
        logic [31:0] rdata;
        logic        err;
        char_t       ch;
        apb_write(ADDR_CTRL, 32'h2);
        apb_read(ADDR_STATUS, rdata, err);
        check_status({row_name[r], "_rearm"}, SCAN_MATCH, '0, 1'b0, rdata);
        for (int i = 0; i < `PATTERN_SIZE; i++) begin
            apb_write(`APB_ADDR_BITS'(ADDR_PATTERN + 4 * i), {24'h0, row_pat[r][i]});
        end
        for (int i = 0; i < `PATTERN_SIZE; i++) begin
            apb_read(`APB_ADDR_BITS'(ADDR_PATTERN + 4 * i), rdata, err);
            check_char({row_name[r], "_readback"}, row_pat[r][i], rdata[7:0]);
            check_flag({row_name[r], "_pslverr"}, 1'b0, err);
        end
        apb_write(ADDR_CTRL, {31'h0, row_en[r]});
        // enable reads back, the rearm bit reads zero
        apb_read(ADDR_CTRL, rdata, err);
        check_flag({row_name[r], "_ctrl_readback"}, 1'b1, rdata == {31'h0, row_en[r]});
        got.delete();
        for (int i = 0; i < row_len[r]; i++) begin
            if (row_chars[r][i][8]) begin
                do begin
                    ch = char_t'($urandom);
                end while (ch == row_pat[r][0]);
            end else begin
                ch = row_chars[r][i][7:0];
            end
            uart_send(ch, i == row_bad[r]);
        end
        // info strobe trails char_valid by one cycle
        repeat (4) @(negedge clk);
        apb_read(ADDR_STATUS, rdata, err);
        check_status(row_name[r], row_state[r], info_cnt_t'(row_info[r].len()),
                     row_frame[r], rdata);
        check_count(row_name[r], row_info[r].len(), got.size());
        for (int i = 0; i < got.size(); i++) begin
            check_char({row_name[r], "_info"}, row_info[r][i], got[i]);
        end
    endtask

    initial begin
        logic [31:0] rdata;
        logic        err;
        int          total;
        void'($urandom(3658));
        rst     = 1'b1;
        psel    = 1'b0;
        penable = 1'b0;
        pwrite  = 1'b0;
        paddr   = '0;
        pwdata  = '0;
        rx      = 1'b1;
        build_table();
        total = 0;
        for (int r = 0; r < NUM_ROWS; r++) begin
            total += row_len[r];
        end
        // twelve bit times per character plus bus traffic and reset
        watch_cycles = total * 12 * `CLKS_PER_BIT + NUM_ROWS * 120 + 400;
        table_ready  = 1'b1;
        repeat (8) @(negedge clk);
        rst = 1'b0;
        apb_read(8'h08, rdata, err);
        check_flag("unmapped_pslverr", 1'b1, err);
        check_flag("unmapped_reads_zero", 1'b1, rdata == 32'h0);
        for (int r = 0; r < NUM_ROWS; r++) begin
            run_row(r);
        end
        $display("Test completed successfully");
        $finish;
    end

    initial begin
        wait (table_ready);
        repeat (watch_cycles) @(posedge clk);
        $display("timeout: the tests did not finish within %0d clock cycles", watch_cycles);
        stop_on_error();
    end

endmodule

`default_nettype wire

// ==== vlog.f ====
+incdir+hw
hw/uart_pkg.sv
hw/scan_pkg.sv
hw/pattern_cfg_if.sv
hw/uart_rx.sv
hw/pattern_search.sv
hw/pattern_apb_regs.sv
hw/pattern_top.sv
verification/pattern_properties.sv
verification/pattern_tb.sv
